//--- design/sdhc_pkg.sv
/* Shared types and constants of the SD host command path.
   Short responses only (R1/R3/R6/R7), no DAT lines. */
package sdhc_pkg;

  localparam int unsigned CmdFrameBits   = 48;
  localparam int unsigned RspTimeoutClks = 64;
  localparam int unsigned RspTimerW      = $clog2(RspTimeoutClks);
  localparam int unsigned NumInts        = 5;

  localparam logic [7:0] RegArgument     = 8'h00;
  localparam logic [7:0] RegCommand      = 8'h04;
  localparam logic [7:0] RegResponse     = 8'h08;
  localparam logic [7:0] RegRspIndex     = 8'h0C;
  localparam logic [7:0] RegClockCtrl    = 8'h10;
  localparam logic [7:0] RegIntStatus    = 8'h14;
  localparam logic [7:0] RegIntEnable    = 8'h18;
  localparam logic [7:0] RegPresentState = 8'h1C;

  localparam int unsigned CmdRspExpBit  = 8; // Response expected bit of COMMAND
  localparam int unsigned ClkEnableBit  = 8; // SD clock enable bit of CLOCK_CTRL
  localparam int unsigned SoftResetBit  = 8; // Cmd line reset bit of PRESENT_STATE

  localparam int unsigned IntCmdComplete = 0;
  localparam int unsigned IntCmdTimeout  = 1;
  localparam int unsigned IntCmdCrc      = 2;
  localparam int unsigned IntCmdEndBit   = 3;
  localparam int unsigned IntCmdIndex    = 4;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlverr = 2'b10;

  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic               cmd_start;
    logic [31:0]        argument;
    logic [5:0]         cmd_index;
    logic               rsp_expected;
    logic [7:0]         clk_divider;
    logic               sd_clk_enable;
    logic [NumInts-1:0] int_enable;
    logic               soft_reset_cmd;
  } reg2hw_t;

  typedef struct packed {
    logic [31:0]        rsp_status;
    logic [5:0]         rsp_index;
    logic               rsp_valid;
    logic [NumInts-1:0] int_events;
    logic               command_inhibit;
    logic               cmd_line_level;
  } hw2reg_t;

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] argument;
  } cmd_frame_t;

  typedef struct packed {
    logic        done;
    logic        timeout;
    logic        crc_error;
    logic        end_bit_error;
    logic [5:0]  index;
    logic [31:0] status;
  } rsp_result_t;

  // One MSB-first CRC7 step with x^7 + x^3 + 1
  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

endpackage

//--- design/sdhc_clk_div.sv
/* SD clock divider, half period is divider_i + 1 clock cycles.
   The clock parks low while disabled. */
module sdhc_clk_div (
  input  logic       clk_i,
  input  logic       software_reset_cmd_q,
  input  logic [7:0] divider_i,
  input  logic       enable_i,
  output logic       sd_clk_o,
  output logic       clk_en_p_o,
  output logic       clk_en_n_o
);
  logic [7:0] cnt_q;
  logic       sd_clk_q, en_p_q, en_n_q, wrap;

  assign wrap = (cnt_q >= divider_i); // Also catches a divider lowered mid count

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q || !enable_i) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;
      en_p_q   <= 1'b0;
      en_n_q   <= 1'b0;
    end else begin
      en_p_q <= wrap & ~sd_clk_q;
      en_n_q <= wrap & sd_clk_q;
      if (wrap) begin
        cnt_q    <= '0;
        sd_clk_q <= ~sd_clk_q;
      end else begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

  assign sd_clk_o   = sd_clk_q;
  assign clk_en_p_o = en_p_q; // First cycle after the rising edge
  assign clk_en_n_o = en_n_q;

endmodule

//--- design/sdhc_cmd_tx.sv
/* Command serializer, drives CMD on falling SD clock edges.
   Starts while busy are ignored. */
module sdhc_cmd_tx import sdhc_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       clk_en_n_i,
  input  cmd_frame_t frame_i,
  input  logic       start_i,
  output logic       cmd_o,
  output logic       cmd_oe_o,
  output logic       done_o
);
  logic [CmdFrameBits-9:0] shreg_q; // Start, transmission, index, argument
  logic [5:0]              cnt_q;
  logic [6:0]              crc_q;
  logic                    busy_q, cmd_q, oe_q, done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      crc_q  <= '0;
      cmd_q  <= 1'b1;
      oe_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i && !busy_q) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
        crc_q  <= '0;
      end else if (busy_q && clk_en_n_i) begin
        cnt_q <= cnt_q + 6'd1;
        if (cnt_q < 6'(CmdFrameBits - 8)) begin
          cmd_q <= shreg_q[CmdFrameBits-9];
          oe_q  <= 1'b1;
          crc_q <= crc7_step(crc_q, shreg_q[CmdFrameBits-9]);
        end else if (cnt_q < 6'(CmdFrameBits - 1)) begin
          cmd_q <= crc_q[6];
          crc_q <= {crc_q[5:0], 1'b0};
        end else if (cnt_q == 6'(CmdFrameBits - 1)) begin
          cmd_q <= 1'b1; // End bit
        end else begin
          oe_q   <= 1'b0;
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_q) begin
      shreg_q <= {2'b01, frame_i.index, frame_i.argument};
    end else if (busy_q && clk_en_n_i) begin
      shreg_q <= shreg_q << 1;
    end
  end

  assign cmd_o    = cmd_q;
  assign cmd_oe_o = oe_q;
  assign done_o   = done_q;

endmodule

//--- design/sdhc_rsp_rx.sv
/* Short response receiver, samples CMD on rising SD clock edges.
   CRC7 covers the first 40 bits. Index is checked by the controller. */
module sdhc_rsp_rx import sdhc_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        clk_en_p_i,
  input  logic        arm_i,
  input  logic        cmd_i,
  output rsp_result_t result_o
);
  typedef enum logic [1:0] {Idle, WaitStart, Receive} state_e;

  state_e                 state_q;
  logic [RspTimerW-1:0]   timer_q;
  logic [5:0]             cnt_q;
  logic [6:0]             crc_q;
  logic [CmdFrameBits-3:0] rx_q; // Frame minus start and end bits
  rsp_result_t            result_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= Idle;
      timer_q       <= '0;
      cnt_q         <= '0;
      crc_q         <= '0;
      result_q.done <= 1'b0;
    end else begin
      result_q.done <= 1'b0;
      case (state_q)
        Idle: begin
          if (arm_i) begin
            state_q <= WaitStart;
            timer_q <= '0;
          end
        end
        WaitStart: begin
          if (clk_en_p_i) begin
            if (!cmd_i) begin
              state_q <= Receive;
              cnt_q   <= '0;
              crc_q   <= '0; // Zero start bit leaves CRC at zero
            end else if (timer_q == RspTimerW'(RspTimeoutClks - 1)) begin
              state_q                <= Idle;
              result_q.done          <= 1'b1;
              result_q.timeout       <= 1'b1;
              result_q.crc_error     <= 1'b0;
              result_q.end_bit_error <= 1'b0;
            end else begin
              timer_q <= timer_q + 1'b1;
            end
          end
        end
        Receive: begin
          if (clk_en_p_i) begin
            cnt_q <= cnt_q + 6'd1;
            if (cnt_q < 6'(CmdFrameBits - 9)) crc_q <= crc7_step(crc_q, cmd_i);
            if (cnt_q == 6'(CmdFrameBits - 2)) begin
              state_q                <= Idle;
              result_q.done          <= 1'b1;
              result_q.timeout       <= 1'b0;
              result_q.crc_error     <= (rx_q[6:0] != crc_q);
              result_q.end_bit_error <= ~cmd_i;
              result_q.index         <= rx_q[44:39];
              result_q.status        <= rx_q[38:7];
            end
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Receive && clk_en_p_i) rx_q <= {rx_q[CmdFrameBits-4:0], cmd_i};
  end

  assign result_o = result_q;

endmodule

//--- design/sdhc_ctrl.sv
/* Command line control: inhibit, resets and interrupt events.
   A response timeout also resets the command line. */
module sdhc_ctrl import sdhc_pkg::*; (
  input  logic               clk_i,
  input  logic               software_reset_cmd_q,
  input  reg2hw_t            reg2hw_i,
  output hw2reg_t            hw2reg_o,
  input  logic [NumInts-1:0] int_status_i,
  output logic               interrupt_o,
  output logic               cmd_reset_o,
  output cmd_frame_t         frame_o,
  output logic               tx_start_o,
  input  logic               tx_done_i,
  output logic               rsp_arm_o,
  input  rsp_result_t        rsp_i,
  input  logic               sd_cmd_i
);
  logic               inhibit_q, rsp_exp_q, irq_q, rsp_ok;
  logic [5:0]         exp_index_q;
  logic [NumInts-1:0] events;

  assign cmd_reset_o = software_reset_cmd_q | reg2hw_i.soft_reset_cmd
                     | (rsp_i.done & rsp_i.timeout);

  assign frame_o    = '{index: reg2hw_i.cmd_index, argument: reg2hw_i.argument};
  assign tx_start_o = reg2hw_i.cmd_start;
  assign rsp_arm_o  = tx_done_i & rsp_exp_q;
  assign rsp_ok     = rsp_i.done & ~rsp_i.timeout & ~rsp_i.crc_error & ~rsp_i.end_bit_error;

  always_comb begin
    events                 = '0;
    events[IntCmdComplete] = (tx_done_i & ~rsp_exp_q) | (rsp_ok & (rsp_i.index == exp_index_q));
    events[IntCmdTimeout]  = rsp_i.done & rsp_i.timeout;
    events[IntCmdCrc]      = rsp_i.done & rsp_i.crc_error;
    events[IntCmdEndBit]   = rsp_i.done & rsp_i.end_bit_error;
    events[IntCmdIndex]    = rsp_ok & (rsp_i.index != exp_index_q);
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      inhibit_q <= 1'b0;
      rsp_exp_q <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      irq_q <= |(int_status_i & reg2hw_i.int_enable);
      if (reg2hw_i.soft_reset_cmd) begin
        inhibit_q <= 1'b0;
      end else if (reg2hw_i.cmd_start) begin
        inhibit_q <= 1'b1;
        rsp_exp_q <= reg2hw_i.rsp_expected;
      end else if ((tx_done_i && !rsp_exp_q) || rsp_i.done) begin
        inhibit_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg2hw_i.cmd_start) exp_index_q <= reg2hw_i.cmd_index;
  end

  assign hw2reg_o = '{
    rsp_status:      rsp_i.status,
    rsp_index:       rsp_i.index,
    rsp_valid:       rsp_i.done & ~rsp_i.timeout,
    int_events:      events,
    command_inhibit: inhibit_q | reg2hw_i.cmd_start, // Covers the start cycle
    cmd_line_level:  sd_cmd_i
  };

  assign interrupt_o = irq_q;

endmodule

//--- design/sdhc_axil_regs.sv
/* AXI4-Lite register file, one outstanding write and one outstanding read.
   Partial strobes mask the written bits. INT_STATUS is write-one-to-clear. */
module sdhc_axil_regs import sdhc_pkg::*; (
  input  logic               clk_i,
  input  logic               software_reset_cmd_q,
  input  axil_req_t          axil_req_i,
  output axil_rsp_t          axil_rsp_o,
  output reg2hw_t            reg2hw_o,
  input  hw2reg_t            hw2reg_i,
  output logic [NumInts-1:0] int_status_o
);
  logic               wr_hs, ar_hs, wr_err, rd_err;
  logic [31:0]        wmask, wd, rd_data;
  logic [NumInts-1:0] status_clr;

  logic               bvalid_q, rvalid_q, cmd_start_q, soft_rst_q, rsp_exp_q, clk_en_q;
  logic [1:0]         bresp_q, rresp_q;
  logic [31:0]        arg_q, rsp_status_q, rdata_q;
  logic [5:0]         cmd_index_q, rsp_index_q;
  logic [7:0]         div_q;
  logic [NumInts-1:0] int_en_q, int_status_q;

  assign wr_hs = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign ar_hs = axil_req_i.arvalid & ~rvalid_q;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      wmask[8*b +: 8] = {8{axil_req_i.wstrb[b]}};
    end
  end
  assign wd = axil_req_i.wdata & wmask;

  assign status_clr = (wr_hs && axil_req_i.awaddr == RegIntStatus) ? wd[NumInts-1:0] : '0;

  always_comb begin
    case (axil_req_i.awaddr)
      RegArgument, RegCommand, RegClockCtrl,
      RegIntStatus, RegIntEnable, RegPresentState: wr_err = 1'b0;
      default: wr_err = 1'b1; // Unmapped or read only
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (axil_req_i.araddr)
      RegArgument: rd_data = arg_q;
      RegCommand: begin
        rd_data[5:0]         = cmd_index_q;
        rd_data[CmdRspExpBit] = rsp_exp_q;
      end
      RegResponse: rd_data = rsp_status_q;
      RegRspIndex: rd_data[5:0] = rsp_index_q;
      RegClockCtrl: begin
        rd_data[7:0]          = div_q;
        rd_data[ClkEnableBit] = clk_en_q;
      end
      RegIntStatus: rd_data[NumInts-1:0] = int_status_q;
      RegIntEnable: rd_data[NumInts-1:0] = int_en_q;
      RegPresentState: rd_data[1:0] = {hw2reg_i.cmd_line_level, hw2reg_i.command_inhibit};
      default: rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      bvalid_q     <= 1'b0;
      bresp_q      <= RespOkay;
      rvalid_q     <= 1'b0;
      rresp_q      <= RespOkay;
      cmd_start_q  <= 1'b0;
      soft_rst_q   <= 1'b0;
      cmd_index_q  <= '0;
      rsp_exp_q    <= 1'b0;
      div_q        <= '0;
      clk_en_q     <= 1'b0;
      int_en_q     <= '0;
      int_status_q <= '0;
    end else begin
      cmd_start_q  <= 1'b0;
      soft_rst_q   <= 1'b0;
      int_status_q <= (int_status_q & ~status_clr) | hw2reg_i.int_events; // Set wins
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_err ? RespSlverr : RespOkay;
        case (axil_req_i.awaddr)
          RegCommand: begin
            if (!hw2reg_i.command_inhibit) begin // Dropped while inhibited
              cmd_index_q <= wd[5:0];
              rsp_exp_q   <= wd[CmdRspExpBit];
              cmd_start_q <= 1'b1;
            end
          end
          RegClockCtrl: begin
            div_q    <= wd[7:0];
            clk_en_q <= wd[ClkEnableBit];
          end
          RegIntEnable:    int_en_q   <= wd[NumInts-1:0];
          RegPresentState: soft_rst_q <= wd[SoftResetBit];
          default: ;
        endcase
      end else if (bvalid_q && axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_err ? RespSlverr : RespOkay;
      end else if (rvalid_q && axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs && axil_req_i.awaddr == RegArgument) arg_q <= (arg_q & ~wmask) | wd;
    if (hw2reg_i.rsp_valid) begin
      rsp_status_q <= hw2reg_i.rsp_status;
      rsp_index_q  <= hw2reg_i.rsp_index;
    end
    if (ar_hs) rdata_q <= rd_data;
  end

  assign axil_rsp_o = '{
    awready: wr_hs,
    wready:  wr_hs,
    bvalid:  bvalid_q,
    bresp:   bresp_q,
    arready: ~rvalid_q,
    rvalid:  rvalid_q,
    rdata:   rdata_q,
    rresp:   rresp_q
  };

  assign reg2hw_o = '{
    cmd_start:      cmd_start_q,
    argument:       arg_q,
    cmd_index:      cmd_index_q,
    rsp_expected:   rsp_exp_q,
    clk_divider:    div_q,
    sd_clk_enable:  clk_en_q,
    int_enable:     int_en_q,
    soft_reset_cmd: soft_rst_q
  };

  assign int_status_o = int_status_q;

endmodule

//--- design/sdhc_top.sv
/* SD host command-line subsystem with an AXI4-Lite register port.
   CMD pin split into output, enable and input, no tristate here. */
module sdhc_top import sdhc_pkg::*; (
  input  logic      clk_i,
  input  logic      software_reset_cmd_q,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output logic      sd_clk_o,
  output logic      sd_cmd_o,
  output logic      sd_cmd_oe_o,
  input  logic      sd_cmd_i,
  output logic      interrupt_o
);
  reg2hw_t            reg2hw;
  hw2reg_t            hw2reg;
  cmd_frame_t         frame;
  rsp_result_t        rsp_result;
  logic [NumInts-1:0] int_status;
  logic               cmd_reset, tx_start, tx_done, rsp_arm, clk_en_p, clk_en_n;

  sdhc_axil_regs u_regs (
    .clk_i,
    .software_reset_cmd_q,
    .axil_req_i,
    .axil_rsp_o,
    .reg2hw_o     (reg2hw),
    .hw2reg_i     (hw2reg),
    .int_status_o (int_status)
  );

  sdhc_ctrl u_ctrl (
    .clk_i,
    .software_reset_cmd_q,
    .reg2hw_i     (reg2hw),
    .hw2reg_o     (hw2reg),
    .int_status_i (int_status),
    .interrupt_o,
    .cmd_reset_o  (cmd_reset),
    .frame_o      (frame),
    .tx_start_o   (tx_start),
    .tx_done_i    (tx_done),
    .rsp_arm_o    (rsp_arm),
    .rsp_i        (rsp_result),
    .sd_cmd_i
  );

  sdhc_clk_div u_clk_div (
    .clk_i,
    .software_reset_cmd_q,
    .divider_i  (reg2hw.clk_divider),
    .enable_i   (reg2hw.sd_clk_enable),
    .sd_clk_o,
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  sdhc_cmd_tx u_cmd_tx (
    .clk_i,
    .reset_i    (cmd_reset),
    .clk_en_n_i (clk_en_n),
    .frame_i    (frame),
    .start_i    (tx_start),
    .cmd_o      (sd_cmd_o),
    .cmd_oe_o   (sd_cmd_oe_o),
    .done_o     (tx_done)
  );

  sdhc_rsp_rx u_rsp_rx (
    .clk_i,
    .reset_i    (cmd_reset),
    .clk_en_p_i (clk_en_p),
    .arm_i      (rsp_arm),
    .cmd_i      (sd_cmd_i),
    .result_o   (rsp_result)
  );

endmodule

//--- sim/sd_card_model.sv
/* Behavioral SD card, command line only. Mode 0 answers correctly, 1 with a bad CRC,
   2 with a wrong index, 3 with a bad end bit, 4 stays silent.
   A frame cut short by the host output enable is dropped. */
module sd_card_model (
  input  logic        sd_clk_i,
  input  logic        cmd_i,      // Line level seen by the card
  input  logic        host_oe_i,
  input  logic [2:0]  mode_i,
  input  logic [31:0] status_i,
  output logic        cmd_o,
  output logic        cmd_oe_o,
  output logic [47:0] frame_o,
  output int unsigned frame_count_o
);
  logic [47:0] shift;
  logic [47:0] rsp;
  logic [6:0]  crc;
  logic [5:0]  idx;
  int          bit_cnt;

  // CRC7 with x^7 + x^3 + 1 over the 40 leading bits
  function automatic logic [6:0] rsp_crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c  = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09;
    end
    return c;
  endfunction

  initial begin
    cmd_o         = 1'b1;
    cmd_oe_o      = 1'b0;
    frame_o       = '0;
    frame_count_o = 0;
    forever begin
      @(posedge sd_clk_i);
      if (host_oe_i === 1'b1 && cmd_i === 1'b0) begin
        shift   = '0; // Start bit already seen
        bit_cnt = 47;
        while (bit_cnt > 0 && host_oe_i === 1'b1) begin
          @(posedge sd_clk_i);
          bit_cnt--;
          shift[bit_cnt] = cmd_i;
        end
        if (bit_cnt == 0 && host_oe_i === 1'b1) begin
          frame_o = shift;
          frame_count_o++;
          if (mode_i != 3'd4) begin
            idx = (mode_i == 3'd2) ? shift[45:40] ^ 6'h01 : shift[45:40];
            crc = rsp_crc7({2'b00, idx, status_i});
            if (mode_i == 3'd1) crc = crc ^ 7'h01;
            rsp = {2'b00, idx, status_i, crc, (mode_i != 3'd3)};
            repeat (8) @(negedge sd_clk_i);
            cmd_oe_o = 1'b1;
            for (int i = 47; i >= 0; i--) begin
              cmd_o = rsp[i]; // Host samples on the rising edge
              @(negedge sd_clk_i);
            end
            cmd_o    = 1'b1;
            cmd_oe_o = 1'b0;
          end
        end
      end
    end
  end

endmodule

//--- sim/tb_sdhc_top.sv
/* Table-driven testbench for the SD host command path.
   CMD line is the host driver, else the card driver, else pulled up. */
module tb_sdhc_top import sdhc_pkg::*; ();

  localparam int unsigned ClkPeriod    = 10;
  localparam int unsigned Divider      = 1;
  localparam int unsigned SdPeriodClks = 2 * (Divider + 1);
  localparam int unsigned NumCmds      = 8;
  localparam int unsigned CmdWorstClks = (2 * CmdFrameBits + RspTimeoutClks + 16) * SdPeriodClks
                                       + 200;
  localparam int unsigned WatchdogTime = (NumCmds + 4) * CmdWorstClks * ClkPeriod;

  localparam logic [2:0] ModeOk       = 3'd0;
  localparam logic [2:0] ModeBadCrc   = 3'd1;
  localparam logic [2:0] ModeBadIndex = 3'd2;
  localparam logic [2:0] ModeBadEnd   = 3'd3;
  localparam logic [2:0] ModeSilent   = 3'd4;

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] argument;
    logic        rsp_exp;
    logic [2:0]  mode;
    logic [4:0]  exp_status;
  } cmd_row_t;

  // index, argument, response expected, card mode, expected INT_STATUS
  cmd_row_t cmd_table [NumCmds] = '{
    {6'd0,  32'h0000_0000, 1'b0, ModeSilent,   5'h01},
    {6'd8,  32'h0000_01aa, 1'b1, ModeOk,       5'h01},
    {6'd55, 32'h0000_0000, 1'b1, ModeOk,       5'h01},
    {6'd41, 32'h40ff_8000, 1'b1, ModeBadCrc,   5'h04},
    {6'd3,  32'h0000_0000, 1'b1, ModeBadIndex, 5'h10},
    {6'd7,  32'h1234_0000, 1'b1, ModeBadEnd,   5'h08},
    {6'd9,  32'h1234_0000, 1'b1, ModeSilent,   5'h02},
    {6'd16, 32'h0000_0200, 1'b1, ModeOk,       5'h01}
  };

  logic        clk_i = 1'b0;
  logic        software_reset_cmd_q;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        sd_clk, sd_cmd, sd_cmd_oe, cmd_line, irq;
  logic        card_cmd, card_oe;
  logic [2:0]  card_mode;
  logic [31:0] card_status;
  logic [47:0] card_frame;
  int unsigned card_count;
  logic [31:0] rng_state = 32'hd193;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  assign cmd_line = sd_cmd_oe ? sd_cmd : (card_oe ? card_cmd : 1'b1);

  sdhc_top u_dut (
    .clk_i,
    .software_reset_cmd_q,
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .sd_clk_o    (sd_clk),
    .sd_cmd_o    (sd_cmd),
    .sd_cmd_oe_o (sd_cmd_oe),
    .sd_cmd_i    (cmd_line),
    .interrupt_o (irq)
  );

  sd_card_model u_card (
    .sd_clk_i      (sd_clk),
    .cmd_i         (cmd_line),
    .host_oe_i     (sd_cmd_oe),
    .mode_i        (card_mode),
    .status_i      (card_status),
    .cmd_o         (card_cmd),
    .cmd_oe_o      (card_oe),
    .frame_o       (card_frame),
    .frame_count_o (card_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [6:0] frame_crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  // Start 0, transmission 1, index, argument, CRC7, end 1
  function automatic logic [47:0] build_frame(input logic [5:0] index, input logic [31:0] arg);
    return {2'b01, index, arg, frame_crc7({2'b01, index, arg}), 1'b1};
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] got_val);
    if (got_val !== exp_val) begin
      $display("Error %s expected 0x%0h got 0x%0h", name, exp_val, got_val);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.bready  = 1'b1;
    @(negedge clk_i);
    while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    @(negedge clk_i);
    while (!axil_rsp.bvalid) @(negedge clk_i);
    resp = axil_rsp.bresp;
    @(posedge clk_i);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    @(negedge clk_i);
    while (!axil_rsp.arready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    axil_req.arvalid = 1'b0;
    @(negedge clk_i);
    while (!axil_rsp.rvalid) @(negedge clk_i);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk_i);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_value("bresp", RespOkay, resp);
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_value("rresp", RespOkay, resp);
  endtask

  // Poll PRESENT_STATE until inhibit clears
  task automatic wait_not_inhibited();
    logic [31:0] st;
    st = 32'h1;
    while (st[0]) reg_read(RegPresentState, st);
  endtask

  task automatic run_command(input cmd_row_t row);
    logic [31:0] data, en;
    logic [5:0]  exp_idx;
    int unsigned count_before;
    rng_state   = xorshift32(rng_state);
    card_status = rng_state;
    card_mode   = row.mode;
    rng_state   = xorshift32(rng_state);
    en          = {27'd0, rng_state[4:0]};
    reg_write(RegIntEnable, en);
    reg_write(RegArgument, row.argument);
    count_before       = card_count;
    data               = '0;
    data[5:0]          = row.index;
    data[CmdRspExpBit] = row.rsp_exp;
    reg_write(RegCommand, data);
    wait_not_inhibited();
    check_value("card frame count", count_before + 1, card_count);
    check_value("card frame", build_frame(row.index, row.argument), card_frame);
    reg_read(RegCommand, data);
    check_value("COMMAND", {row.rsp_exp, 2'b00, row.index}, data);
    reg_read(RegIntStatus, data);
    check_value("INT_STATUS", row.exp_status, data);
    check_value("interrupt_o", |(row.exp_status & en[4:0]), irq);
    if (row.rsp_exp && row.mode != ModeSilent) begin
      exp_idx = (row.mode == ModeBadIndex) ? row.index ^ 6'h01 : row.index;
      reg_read(RegResponse, data);
      check_value("RESPONSE", card_status, data);
      reg_read(RegRspIndex, data);
      check_value("RSP_INDEX", exp_idx, data);
    end
    reg_write(RegIntStatus, row.exp_status); // Write ones back
    reg_read(RegIntStatus, data);
    check_value("INT_STATUS cleared", 0, data);
    check_value("interrupt_o cleared", 0, irq);
  endtask

  initial begin
    #(WatchdogTime);
    $display("Timeout: the tests did not finish within %0d time units", WatchdogTime);
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin : main
    logic [31:0] data;
    logic [1:0]  resp;
    int unsigned count_before;
    axil_req             = '0;
    software_reset_cmd_q = 1'b1;
    card_mode            = ModeSilent;
    card_status          = '0;
    repeat (8) @(posedge clk_i);
    #1;
    software_reset_cmd_q = 1'b0;

    // Register access
    reg_read(RegPresentState, data);
    check_value("PRESENT_STATE", 32'h2, data);
    reg_write(RegArgument, 32'ha5c3_5a3c);
    reg_read(RegArgument, data);
    check_value("ARGUMENT", 32'ha5c3_5a3c, data);
    reg_write(RegClockCtrl, 32'h0000_01c7);
    reg_read(RegClockCtrl, data);
    check_value("CLOCK_CTRL", 32'h0000_01c7, data);
    reg_write(RegIntEnable, 32'hffff_ffea);
    reg_read(RegIntEnable, data);
    check_value("INT_ENABLE", 32'h0000_000a, data);
    axil_write(8'h20, 32'h1, resp);
    check_value("bresp unmapped", RespSlverr, resp);
    axil_write(RegResponse, 32'h1, resp);
    check_value("bresp read-only", RespSlverr, resp);
    axil_read(8'h24, data, resp);
    check_value("rresp unmapped", RespSlverr, resp);
    check_value("rdata unmapped", 0, data);
    reg_write(RegClockCtrl, (32'h1 << ClkEnableBit) | Divider);

    for (int r = 0; r < NumCmds; r++) run_command(cmd_table[r]);

    // Second COMMAND write lands while inhibited
    card_mode    = ModeSilent;
    count_before = card_count;
    reg_write(RegArgument, 32'h0000_0000);
    reg_write(RegCommand, 32'h0000_000c);
    reg_write(RegCommand, 32'h0000_000d);
    wait_not_inhibited();
    check_value("card frame count", count_before + 1, card_count);
    check_value("card frame", build_frame(6'd12, 32'h0), card_frame);
    reg_write(RegIntStatus, 32'h1f);

    // Soft reset in the middle of a frame
    card_mode    = ModeOk;
    count_before = card_count;
    reg_write(RegArgument, 32'hdead_beef);
    reg_write(RegCommand, 32'h0000_0111);
    reg_read(RegPresentState, data);
    check_value("inhibit during command", 1, data[0]);
    reg_write(RegPresentState, 32'h1 << SoftResetBit);
    reg_read(RegPresentState, data);
    check_value("inhibit after soft reset", 0, data[0]);
    reg_read(RegIntStatus, data);
    check_value("INT_STATUS after soft reset", 0, data);
    check_value("card frame count", count_before, card_count);
    run_command({6'd13, 32'h0000_0001, 1'b1, ModeOk, 5'h01});

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- sdhc_top.f
design/sdhc_pkg.sv
design/sdhc_clk_div.sv
design/sdhc_cmd_tx.sv
design/sdhc_rsp_rx.sv
design/sdhc_ctrl.sv
design/sdhc_axil_regs.sv
design/sdhc_top.sv
sim/sd_card_model.sv
sim/tb_sdhc_top.sv

//--- Bender.yml
package:
  name: sdhc_top

sources:
  - files:
      - design/sdhc_pkg.sv
      - design/sdhc_clk_div.sv
      - design/sdhc_cmd_tx.sv
      - design/sdhc_rsp_rx.sv
      - design/sdhc_ctrl.sv
      - design/sdhc_axil_regs.sv
      - design/sdhc_top.sv
  - target: simulation
    files:
      - sim/sd_card_model.sv
      - sim/tb_sdhc_top.sv
